/* rtl/upm_pkg.sv */
// upm_pkg: bus widths, response codes, opcodes, states, register map and packed structs
`default_nettype none

package upm_pkg;

	// ------------------------------
	// axi4-lite bus
	// ------------------------------
	localparam int UPM_AXIL_ADDR_W = 8;
	localparam int UPM_AXIL_DATA_W = 32;

	// response codes
	localparam logic [1:0] UPM_RESP_OKAY   = 2'b00;
	localparam logic [1:0] UPM_RESP_SLVERR = 2'b10;

	// ------------------------------
	// enums
	// ------------------------------
	// one-cycle command from decode to the engine
	typedef enum logic [1:0] {
		UPM_CMD_NONE  = 2'd0,
		UPM_CMD_START = 2'd1,
		UPM_CMD_STOP  = 2'd2
	} upm_cmd_e;

	// engine states, also visible in status
	typedef enum logic [1:0] {
		UPM_ST_IDLE = 2'd0,
		UPM_ST_RUN  = 2'd1,
		UPM_ST_DONE = 2'd2
	} upm_state_e;

	// register byte offsets
	typedef enum logic [UPM_AXIL_ADDR_W-1:0] {
		UPM_REG_CTRL     = 8'h00,
		UPM_REG_WINDOW   = 8'h04,
		UPM_REG_APM_CTRL = 8'h08,
		UPM_REG_STATUS   = 8'h0C,
		UPM_REG_COUNT0   = 8'h10,
		UPM_REG_COUNT1   = 8'h14,
		UPM_REG_ELAPSED  = 8'h18
	} upm_reg_e;

	// ------------------------------
	// structs
	// ------------------------------
	// window_mode 1 ends on expiry, 0 runs until stop
	typedef struct packed {
		upm_cmd_e cmd;
		logic     window_mode;
	} upm_ctrl_t;

	// field order gives the apm_ctrl register layout, en_sensor at bit 0
	typedef struct packed {
		logic [3:0] vdac_sel;
		logic [3:0] mux_sel;
		logic [1:0] xtor_sel;
		logic       osc_sel;
		logic       en_step;
		logic       en_osc;
		logic       en_cal;
		logic       en_sensor;
	} upm_apm_ctrl_t;

	// status register bits 4:0
	typedef struct packed {
		upm_state_e state;
		logic       done;
		logic [1:0] overflow;
	} upm_status_t;

endpackage

`default_nettype wire

/* rtl/upm_osc_sync.sv */
// upm_osc_sync: two-flop synchronizer and rising edge detect for both oscillator channels
`default_nettype none

module upm_osc_sync (
	input  wire logic       dfx_upm_func_clk_i,
	input  wire logic       rst_n_i,
	// channel 0 apm oscillator, channel 1 aux oscillator
	input  wire logic [1:0] osc_i,
	output logic [1:0]      edge_o
);

	// first stage may go metastable
	logic [1:0] meta_q;
	// stable synchronized level
	logic [1:0] sync_q;
	// previous synchronized level for edge detect
	logic [1:0] prev_q;

	// ------------------------------
	// synchronizer chain
	// ------------------------------
	always_ff @(posedge dfx_upm_func_clk_i) begin
		if (!rst_n_i) begin
			meta_q <= '0;
			sync_q <= '0;
			prev_q <= '0;
		end else begin
			meta_q <= osc_i;
			sync_q <= meta_q;
			prev_q <= sync_q;
		end
	end

	// one pulse per oscillator period
	// high while the new level sits in sync_q
	assign edge_o = sync_q & ~prev_q;

endmodule

`default_nettype wire

/* rtl/upm_axil_regs.sv */
// upm_axil_regs: axi4-lite slave with control, window and apm registers and result read mux
`default_nettype none

module upm_axil_regs #(
	parameter int WINDOW_W = 16,
	parameter int COUNT_W  = 20
) (
	input  wire logic                                     dfx_upm_func_clk_i,
	input  wire logic                                     rst_n_i,
	// write address and data
	input  wire logic [upm_pkg::UPM_AXIL_ADDR_W-1:0]      s_axil_awaddr_i,
	input  wire logic                                     s_axil_awvalid_i,
	output logic                                          s_axil_awready_o,
	input  wire logic [upm_pkg::UPM_AXIL_DATA_W-1:0]      s_axil_wdata_i,
	input  wire logic [upm_pkg::UPM_AXIL_DATA_W/8-1:0]    s_axil_wstrb_i,
	input  wire logic                                     s_axil_wvalid_i,
	output logic                                          s_axil_wready_o,
	// write response
	output logic                                          s_axil_bvalid_o,
	output logic [1:0]                                    s_axil_bresp_o,
	input  wire logic                                     s_axil_bready_i,
	// read address and data
	input  wire logic [upm_pkg::UPM_AXIL_ADDR_W-1:0]      s_axil_araddr_i,
	input  wire logic                                     s_axil_arvalid_i,
	output logic                                          s_axil_arready_o,
	output logic                                          s_axil_rvalid_o,
	output logic [upm_pkg::UPM_AXIL_DATA_W-1:0]           s_axil_rdata_o,
	output logic [1:0]                                    s_axil_rresp_o,
	input  wire logic                                     s_axil_rready_i,
	// towards the engine and the pins
	output upm_pkg::upm_ctrl_t                            ctrl_o,
	output logic [WINDOW_W-1:0]                           window_len_o,
	output upm_pkg::upm_apm_ctrl_t                        apm_ctrl_o,
	// from the result registers
	input  wire upm_pkg::upm_status_t                     status_i,
	input  wire logic [COUNT_W-1:0]                       count0_i,
	input  wire logic [COUNT_W-1:0]                       count1_i,
	input  wire logic [WINDOW_W-1:0]                      elapsed_i
);

	localparam int DW = upm_pkg::UPM_AXIL_DATA_W;
	localparam int AW = $bits(upm_pkg::upm_apm_ctrl_t);

	logic          wr_hs;
	logic          rd_hs;
	logic          wr_ok;
	logic          rd_ok;
	logic [DW-1:0] rd_data;
	logic [DW-1:0] window_merged;
	logic [DW-1:0] apm_merged;

	// byte lane merge under wstrb
	function automatic logic [DW-1:0] merge_bytes(
		input logic [DW-1:0]   old_v,
		input logic [DW-1:0]   new_v,
		input logic [DW/8-1:0] strb
	);
		logic [DW-1:0] res;
		res = old_v;
		for (int b = 0; b < DW / 8; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_v[8*b +: 8];
		end
		return res;
	endfunction

	// ------------------------------
	// handshakes
	// ------------------------------
	// aw and w accepted together, held off while a response is pending
	assign wr_hs            = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_bvalid_o;
	assign s_axil_awready_o = wr_hs;
	assign s_axil_wready_o  = wr_hs;
	// one read outstanding at a time
	assign rd_hs            = s_axil_arvalid_i & ~s_axil_rvalid_o;
	assign s_axil_arready_o = rd_hs;

	// ------------------------------
	// write path
	// ------------------------------
	// only ctrl, window and apm_ctrl are writable
	always_comb begin
		case (s_axil_awaddr_i)
			upm_pkg::UPM_REG_CTRL,
			upm_pkg::UPM_REG_WINDOW,
			upm_pkg::UPM_REG_APM_CTRL: wr_ok = 1'b1;
			default:                   wr_ok = 1'b0;
		endcase
	end

	assign window_merged = merge_bytes(DW'(window_len_o), s_axil_wdata_i, s_axil_wstrb_i);
	assign apm_merged    = merge_bytes(DW'(apm_ctrl_o), s_axil_wdata_i, s_axil_wstrb_i);

	always_ff @(posedge dfx_upm_func_clk_i) begin
		if (!rst_n_i) begin
			s_axil_bvalid_o    <= 1'b0;
			s_axil_bresp_o     <= upm_pkg::UPM_RESP_OKAY;
			ctrl_o.cmd         <= upm_pkg::UPM_CMD_NONE;
			ctrl_o.window_mode <= 1'b0;
			window_len_o       <= '0;
			apm_ctrl_o         <= '0;
		end else begin
			// command lives for a single cycle
			ctrl_o.cmd <= upm_pkg::UPM_CMD_NONE;
			if (s_axil_bvalid_o && s_axil_bready_i)
				s_axil_bvalid_o <= 1'b0;
			if (wr_hs) begin
				s_axil_bvalid_o <= 1'b1;
				s_axil_bresp_o  <= wr_ok ? upm_pkg::UPM_RESP_OKAY : upm_pkg::UPM_RESP_SLVERR;
				case (s_axil_awaddr_i)
					upm_pkg::UPM_REG_CTRL: begin
						// start wins if both bits are set
						if (s_axil_wstrb_i[0]) begin
							ctrl_o.window_mode <= s_axil_wdata_i[2];
							if (s_axil_wdata_i[0])
								ctrl_o.cmd <= upm_pkg::UPM_CMD_START;
							else if (s_axil_wdata_i[1])
								ctrl_o.cmd <= upm_pkg::UPM_CMD_STOP;
						end
					end
					upm_pkg::UPM_REG_WINDOW:
						window_len_o <= window_merged[WINDOW_W-1:0];
					upm_pkg::UPM_REG_APM_CTRL:
						apm_ctrl_o <= upm_pkg::upm_apm_ctrl_t'(apm_merged[AW-1:0]);
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// read path
	// ------------------------------
	always_comb begin
		rd_data = '0;
		rd_ok   = 1'b1;
		case (s_axil_araddr_i)
			upm_pkg::UPM_REG_CTRL:     rd_data[2]            = ctrl_o.window_mode;
			upm_pkg::UPM_REG_WINDOW:   rd_data[WINDOW_W-1:0] = window_len_o;
			upm_pkg::UPM_REG_APM_CTRL: rd_data[AW-1:0]       = apm_ctrl_o;
			upm_pkg::UPM_REG_STATUS:
				rd_data[$bits(upm_pkg::upm_status_t)-1:0] = status_i;
			upm_pkg::UPM_REG_COUNT0:   rd_data[COUNT_W-1:0]  = count0_i;
			upm_pkg::UPM_REG_COUNT1:   rd_data[COUNT_W-1:0]  = count1_i;
			upm_pkg::UPM_REG_ELAPSED:  rd_data[WINDOW_W-1:0] = elapsed_i;
			// unknown offset reads zero
			default:                   rd_ok = 1'b0;
		endcase
	end

	always_ff @(posedge dfx_upm_func_clk_i) begin
		if (!rst_n_i) begin
			s_axil_rvalid_o <= 1'b0;
			s_axil_rresp_o  <= upm_pkg::UPM_RESP_OKAY;
		end else begin
			if (s_axil_rvalid_o && s_axil_rready_i)
				s_axil_rvalid_o <= 1'b0;
			if (rd_hs) begin
				s_axil_rvalid_o <= 1'b1;
				s_axil_rresp_o  <= rd_ok ? upm_pkg::UPM_RESP_OKAY : upm_pkg::UPM_RESP_SLVERR;
			end
		end
	end

	// read data held with rvalid
	always_ff @(posedge dfx_upm_func_clk_i) begin
		if (rd_hs)
			s_axil_rdata_o <= rd_data;
	end

endmodule

`default_nettype wire

/* rtl/upm_window_engine.sv */
// upm_window_engine: measurement fsm, elapsed window counter and two saturating event counters
`default_nettype none

module upm_window_engine #(
	parameter int WINDOW_W = 16,
	parameter int COUNT_W  = 20
) (
	input  wire logic                dfx_upm_func_clk_i,
	input  wire logic                rst_n_i,
	input  wire upm_pkg::upm_ctrl_t  ctrl_i,
	input  wire logic [WINDOW_W-1:0] window_len_i,
	input  wire logic [1:0]          edge_i,
	output upm_pkg::upm_state_e      state_o,
	output logic                     capture_o,
	output logic [COUNT_W-1:0]       count0_o,
	output logic [COUNT_W-1:0]       count1_o,
	output logic [1:0]               overflow_o,
	output logic [WINDOW_W-1:0]      elapsed_o
);

	// event counters, index is the channel
	logic [COUNT_W-1:0] count_q [2];
	// window mode sampled at start
	logic               mode_q;
	logic               start;
	logic               stop;
	logic               expire;
	// one extra bit so the compare never wraps
	logic [WINDOW_W:0]  elapsed_nxt;

	// ------------------------------
	// end conditions
	// ------------------------------
	// start ignored while running
	assign start = (ctrl_i.cmd == upm_pkg::UPM_CMD_START) && (state_o != upm_pkg::UPM_ST_RUN);
	assign stop  = (ctrl_i.cmd == upm_pkg::UPM_CMD_STOP);

	assign elapsed_nxt = {1'b0, elapsed_o} + 1'b1;
	// this run cycle is the last one of the window
	assign expire = mode_q && (elapsed_nxt >= {1'b0, window_len_i});

	// ------------------------------
	// fsm and counters
	// ------------------------------
	always_ff @(posedge dfx_upm_func_clk_i) begin
		if (!rst_n_i) begin
			state_o    <= upm_pkg::UPM_ST_IDLE;
			mode_q     <= 1'b0;
			elapsed_o  <= '0;
			overflow_o <= '0;
			count_q    <= '{default: '0};
		end else begin
			case (state_o)
				upm_pkg::UPM_ST_IDLE,
				upm_pkg::UPM_ST_DONE: begin
					if (start) begin
						// fresh measurement
						state_o    <= upm_pkg::UPM_ST_RUN;
						mode_q     <= ctrl_i.window_mode;
						elapsed_o  <= '0;
						overflow_o <= '0;
						count_q    <= '{default: '0};
					end else begin
						// done lasts a single cycle
						state_o <= upm_pkg::UPM_ST_IDLE;
					end
				end
				upm_pkg::UPM_ST_RUN: begin
					// elapsed saturates in long stop-mode runs
					if (!(&elapsed_o))
						elapsed_o <= elapsed_nxt[WINDOW_W-1:0];
					for (int ch = 0; ch < 2; ch++) begin
						if (edge_i[ch]) begin
							// edge lost at full scale
							if (&count_q[ch])
								overflow_o[ch] <= 1'b1;
							else
								count_q[ch] <= count_q[ch] + 1'b1;
						end
					end
					// stop ends early in either mode
					if (stop || expire)
						state_o <= upm_pkg::UPM_ST_DONE;
				end
				default: state_o <= upm_pkg::UPM_ST_IDLE;
			endcase
		end
	end

	// values are stable during done
	assign capture_o = (state_o == upm_pkg::UPM_ST_DONE);
	assign count0_o  = count_q[0];
	assign count1_o  = count_q[1];

endmodule

`default_nettype wire

/* rtl/upm_result_regs.sv */
// upm_result_regs: captured counts and elapsed window, sticky done and overflow status
`default_nettype none

module upm_result_regs #(
	parameter int WINDOW_W = 16,
	parameter int COUNT_W  = 20
) (
	input  wire logic                dfx_upm_func_clk_i,
	input  wire logic                rst_n_i,
	input  wire logic                start_i,
	input  wire logic                capture_i,
	input  wire upm_pkg::upm_state_e state_i,
	input  wire logic [COUNT_W-1:0]  count0_i,
	input  wire logic [COUNT_W-1:0]  count1_i,
	input  wire logic [1:0]          overflow_i,
	input  wire logic [WINDOW_W-1:0] elapsed_i,
	output upm_pkg::upm_status_t     status_o,
	output logic [COUNT_W-1:0]       count0_o,
	output logic [COUNT_W-1:0]       count1_o,
	output logic [WINDOW_W-1:0]      elapsed_o
);

	logic       done_q;
	logic [1:0] ovf_q;

	// ------------------------------
	// sticky status
	// ------------------------------
	// start clears before a coincident capture can set
	always_ff @(posedge dfx_upm_func_clk_i) begin
		if (!rst_n_i) begin
			done_q <= 1'b0;
			ovf_q  <= '0;
		end else if (start_i) begin
			done_q <= 1'b0;
			ovf_q  <= '0;
		end else if (capture_i) begin
			done_q <= 1'b1;
			ovf_q  <= ovf_q | overflow_i;
		end
	end

	// results held while the next run proceeds
	always_ff @(posedge dfx_upm_func_clk_i) begin
		if (capture_i) begin
			count0_o  <= count0_i;
			count1_o  <= count1_i;
			elapsed_o <= elapsed_i;
		end
	end

	// state comes live from the engine
	assign status_o.state    = state_i;
	assign status_o.done     = done_q;
	assign status_o.overflow = ovf_q;

endmodule

`default_nettype wire

/* rtl/upm_top.sv */
// upm_top: register front end, oscillator sync, window engine, result registers and apm pins
`default_nettype none

module upm_top #(
	parameter int WINDOW_W = 16,
	parameter int COUNT_W  = 20
) (
	input  wire logic                                  dfx_upm_func_clk_i,
	input  wire logic                                  rst_n_i,
	// axi4-lite slave
	input  wire logic [upm_pkg::UPM_AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
	input  wire logic                                  s_axil_awvalid_i,
	output logic                                       s_axil_awready_o,
	input  wire logic [upm_pkg::UPM_AXIL_DATA_W-1:0]   s_axil_wdata_i,
	input  wire logic [upm_pkg::UPM_AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
	input  wire logic                                  s_axil_wvalid_i,
	output logic                                       s_axil_wready_o,
	output logic                                       s_axil_bvalid_o,
	output logic [1:0]                                 s_axil_bresp_o,
	input  wire logic                                  s_axil_bready_i,
	input  wire logic [upm_pkg::UPM_AXIL_ADDR_W-1:0]   s_axil_araddr_i,
	input  wire logic                                  s_axil_arvalid_i,
	output logic                                       s_axil_arready_o,
	output logic                                       s_axil_rvalid_o,
	output logic [upm_pkg::UPM_AXIL_DATA_W-1:0]        s_axil_rdata_o,
	output logic [1:0]                                 s_axil_rresp_o,
	input  wire logic                                  s_axil_rready_i,
	// sensor oscillators
	input  wire logic                                  apm_osc_out_i,
	input  wire logic                                  aux_osc_i,
	// apm sensor control
	output logic                                       apm_en_sensor_o,
	output logic                                       apm_en_cal_o,
	output logic                                       apm_en_osc_o,
	output logic                                       apm_en_step_o,
	output logic                                       apm_osc_sel_o,
	output logic [1:0]                                 apm_xtor_sel_o,
	output logic [3:0]                                 apm_mux_sel_o,
	output logic [3:0]                                 apm_vdac_sel_o
);

	upm_pkg::upm_ctrl_t     ctrl;
	upm_pkg::upm_apm_ctrl_t apm_ctrl;
	upm_pkg::upm_status_t   status;
	upm_pkg::upm_state_e    eng_state;
	logic [WINDOW_W-1:0]    window_len;
	logic [1:0]             osc_edge;
	logic                   capture;
	logic                   start;
	logic [COUNT_W-1:0]     eng_count0;
	logic [COUNT_W-1:0]     eng_count1;
	logic [1:0]             eng_overflow;
	logic [WINDOW_W-1:0]    eng_elapsed;
	logic [COUNT_W-1:0]     res_count0;
	logic [COUNT_W-1:0]     res_count1;
	logic [WINDOW_W-1:0]    res_elapsed;

	// ------------------------------
	// decode
	// ------------------------------
	upm_axil_regs #(
		.WINDOW_W (WINDOW_W),
		.COUNT_W  (COUNT_W)
	) upm_axil_regs_inst (
		.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
		.rst_n_i            (rst_n_i),
		.s_axil_awaddr_i    (s_axil_awaddr_i),
		.s_axil_awvalid_i   (s_axil_awvalid_i),
		.s_axil_awready_o   (s_axil_awready_o),
		.s_axil_wdata_i     (s_axil_wdata_i),
		.s_axil_wstrb_i     (s_axil_wstrb_i),
		.s_axil_wvalid_i    (s_axil_wvalid_i),
		.s_axil_wready_o    (s_axil_wready_o),
		.s_axil_bvalid_o    (s_axil_bvalid_o),
		.s_axil_bresp_o     (s_axil_bresp_o),
		.s_axil_bready_i    (s_axil_bready_i),
		.s_axil_araddr_i    (s_axil_araddr_i),
		.s_axil_arvalid_i   (s_axil_arvalid_i),
		.s_axil_arready_o   (s_axil_arready_o),
		.s_axil_rvalid_o    (s_axil_rvalid_o),
		.s_axil_rdata_o     (s_axil_rdata_o),
		.s_axil_rresp_o     (s_axil_rresp_o),
		.s_axil_rready_i    (s_axil_rready_i),
		.ctrl_o             (ctrl),
		.window_len_o       (window_len),
		.apm_ctrl_o         (apm_ctrl),
		.status_i           (status),
		.count0_i           (res_count0),
		.count1_i           (res_count1),
		.elapsed_i          (res_elapsed)
	);

	// ------------------------------
	// execute
	// ------------------------------
	// channel 0 apm, channel 1 aux
	upm_osc_sync upm_osc_sync_inst (
		.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
		.rst_n_i            (rst_n_i),
		.osc_i              ({aux_osc_i, apm_osc_out_i}),
		.edge_o             (osc_edge)
	);

	upm_window_engine #(
		.WINDOW_W (WINDOW_W),
		.COUNT_W  (COUNT_W)
	) upm_window_engine_inst (
		.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
		.rst_n_i            (rst_n_i),
		.ctrl_i             (ctrl),
		.window_len_i       (window_len),
		.edge_i             (osc_edge),
		.state_o            (eng_state),
		.capture_o          (capture),
		.count0_o           (eng_count0),
		.count1_o           (eng_count1),
		.overflow_o         (eng_overflow),
		.elapsed_o          (eng_elapsed)
	);

	// ------------------------------
	// result
	// ------------------------------
	assign start = (ctrl.cmd == upm_pkg::UPM_CMD_START);

	upm_result_regs #(
		.WINDOW_W (WINDOW_W),
		.COUNT_W  (COUNT_W)
	) upm_result_regs_inst (
		.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
		.rst_n_i            (rst_n_i),
		.start_i            (start),
		.capture_i          (capture),
		.state_i            (eng_state),
		.count0_i           (eng_count0),
		.count1_i           (eng_count1),
		.overflow_i         (eng_overflow),
		.elapsed_i          (eng_elapsed),
		.status_o           (status),
		.count0_o           (res_count0),
		.count1_o           (res_count1),
		.elapsed_o          (res_elapsed)
	);

	// apm control fields onto the sensor pins
	assign apm_en_sensor_o = apm_ctrl.en_sensor;
	assign apm_en_cal_o    = apm_ctrl.en_cal;
	assign apm_en_osc_o    = apm_ctrl.en_osc;
	assign apm_en_step_o   = apm_ctrl.en_step;
	assign apm_osc_sel_o   = apm_ctrl.osc_sel;
	assign apm_xtor_sel_o  = apm_ctrl.xtor_sel;
	assign apm_mux_sel_o   = apm_ctrl.mux_sel;
	assign apm_vdac_sel_o  = apm_ctrl.vdac_sel;

endmodule

`default_nettype wire

/* sim/upm_tb.sv */
// upm_tb: clock, reset, axi4-lite master, oscillator models, assertions and run limit for upm_top
`default_nettype none

module upm_tb #(
	// a narrow width such as 12 drives the long window into saturation
	parameter int COUNT_W = 20
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WINDOW_W = 16;
	localparam int WIN_LEN  = 200;
	localparam int STOP_MAX = 200;
	// shorter than any stop delay so a wrong expiry shows
	localparam int STOP_WIN = 40;
	localparam int LONG_WIN = 65535;
	// summed windows plus margin for register traffic
	localparam int RUN_LIMIT = WIN_LEN + STOP_MAX + LONG_WIN + 2000;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic [7:0]             awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [31:0]            wdata;
	logic [3:0]             wstrb;
	logic                   wvalid;
	logic                   wready;
	logic                   bvalid;
	logic [1:0]             bresp;
	logic                   bready;
	logic [7:0]             araddr;
	logic                   arvalid;
	logic                   arready;
	logic                   rvalid;
	logic [31:0]            rdata;
	logic [1:0]             rresp;
	logic                   rready;
	// apm pins gathered back into the register layout
	upm_pkg::upm_apm_ctrl_t apm_pins;
	// channel 0 is the apm oscillator and channel 1 the aux oscillator
	logic [1:0]             osc;
	int unsigned            osc_period [2];
	int unsigned            osc_phase [2];
	int unsigned            cycle_cnt = 0;

	always #50 clk = ~clk;

	upm_top #(
		.WINDOW_W (WINDOW_W),
		.COUNT_W  (COUNT_W)
	) upm_top_inst (
		.dfx_upm_func_clk_i (clk),
		.rst_n_i            (rst_n),
		.s_axil_awaddr_i    (awaddr),
		.s_axil_awvalid_i   (awvalid),
		.s_axil_awready_o   (awready),
		.s_axil_wdata_i     (wdata),
		.s_axil_wstrb_i     (wstrb),
		.s_axil_wvalid_i    (wvalid),
		.s_axil_wready_o    (wready),
		.s_axil_bvalid_o    (bvalid),
		.s_axil_bresp_o     (bresp),
		.s_axil_bready_i    (bready),
		.s_axil_araddr_i    (araddr),
		.s_axil_arvalid_i   (arvalid),
		.s_axil_arready_o   (arready),
		.s_axil_rvalid_o    (rvalid),
		.s_axil_rdata_o     (rdata),
		.s_axil_rresp_o     (rresp),
		.s_axil_rready_i    (rready),
		.apm_osc_out_i      (osc[0]),
		.aux_osc_i          (osc[1]),
		.apm_en_sensor_o    (apm_pins.en_sensor),
		.apm_en_cal_o       (apm_pins.en_cal),
		.apm_en_osc_o       (apm_pins.en_osc),
		.apm_en_step_o      (apm_pins.en_step),
		.apm_osc_sel_o      (apm_pins.osc_sel),
		.apm_xtor_sel_o     (apm_pins.xtor_sel),
		.apm_mux_sel_o      (apm_pins.mux_sel),
		.apm_vdac_sel_o     (apm_pins.vdac_sel)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else stop_on_error($sformatf("Fail at %0d ns: %s is 0x%0h, expected 0x%0h",
			$time, what, got, exp));
	endtask

	task automatic check_range(input string what, input int got, input int lo, input int hi);
		assert ((got >= lo) && (got <= hi))
		else stop_on_error($sformatf("Fail at %0d ns: %s is %0d, expected %0d to %0d",
			$time, what, got, lo, hi));
	endtask

	// ------------------------------
	// oscillator models
	// ------------------------------
	// high for the first half of each period and held low at period 0
	always @(negedge clk) begin
		for (int ch = 0; ch < 2; ch++) begin
			if (osc_period[ch] == 0) begin
				osc_phase[ch] = 0;
				osc[ch] = 1'b0;
			end else begin
				osc_phase[ch] = (osc_phase[ch] + 1) % osc_period[ch];
				osc[ch] = (osc_phase[ch] < osc_period[ch] / 2);
			end
		end
	end

	// called right after a rising edge and away from the model's falling edge
	task automatic set_osc_periods(input int unsigned p0, input int unsigned p1);
		osc_period[0] = p0;
		osc_period[1] = p1;
	endtask

	// ------------------------------
	// axi4-lite master
	// ------------------------------
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input logic [1:0] exp_resp, output int unsigned hs_cycle);
		logic hs;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(posedge clk);
			hs = awready && wready;
		end
		hs_cycle = cycle_cnt;
		// response under random bready stalls
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			awvalid = 1'b0;
			wvalid = 1'b0;
			bready = ($urandom % 3) == 0;
			@(posedge clk);
			hs = bvalid && bready;
		end
		check_eq($sformatf("bresp at 0x%02h", addr), bresp, exp_resp);
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic hs;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(posedge clk);
			hs = arready;
		end
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			arvalid = 1'b0;
			rready = ($urandom % 3) == 0;
			@(posedge clk);
			hs = rvalid && rready;
		end
		data = rdata;
		resp = rresp;
	endtask

	task automatic check_read(input string what, input logic [7:0] addr,
			input logic [31:0] exp_data, input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0]  resp;
		read_reg(addr, data, resp);
		check_eq({what, " rresp"}, resp, exp_resp);
		check_eq(what, data, exp_data);
	endtask

	// register read-back and the pins must both match
	task automatic check_apm(input logic [31:0] exp);
		check_read("apm_ctrl", upm_pkg::UPM_REG_APM_CTRL, exp, upm_pkg::UPM_RESP_OKAY);
		check_eq("apm pins", {17'd0, apm_pins}, exp);
	endtask

	// poll status until the sticky done bit shows
	task automatic wait_for_done(output upm_pkg::upm_status_t st);
		logic [31:0] data;
		logic [1:0]  resp;
		st = '0;
		while (!st.done) begin
			read_reg(upm_pkg::UPM_REG_STATUS, data, resp);
			st = upm_pkg::upm_status_t'(data[4:0]);
		end
	endtask

	// ------------------------------
	// assertions and run limit
	// ------------------------------
	// responses stay up until the master takes them
	bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else stop_on_error("write response dropped or changed before bready");

	rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else stop_on_error("read response dropped or changed before rready");

	reset_clears: assert property (@(posedge clk)
		!rst_n |=> !bvalid && !rvalid && apm_pins == '0)
		else stop_on_error($sformatf("Fail at %0d ns: outputs not cleared by reset", $time));

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > RUN_LIMIT)
			stop_on_error($sformatf("timeout, no result after %0d cycles", RUN_LIMIT));
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		logic [31:0]          data;
		logic [1:0]           resp;
		logic [31:0]          apm_exp;
		logic [31:0]          rnd;
		logic [3:0]           strb;
		int unsigned          hs_start;
		int unsigned          hs_stop;
		int unsigned          dummy;
		int unsigned          cnt_max;
		int                   b;
		upm_pkg::upm_status_t st;

		void'($urandom(32'h815396f1));
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		osc = '0;
		osc_period = '{0, 0};
		osc_phase = '{0, 0};
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// reset state
		check_eq("valid outputs after reset", {bvalid, rvalid}, 0);
		check_eq("apm pins after reset", {17'd0, apm_pins}, 0);
		check_read("status after reset", upm_pkg::UPM_REG_STATUS,
			{upm_pkg::UPM_ST_IDLE, 1'b0, 2'b00}, upm_pkg::UPM_RESP_OKAY);

		// register access, byte strobes and bad offsets
		write_reg(upm_pkg::UPM_REG_WINDOW, 32'h0000_abcd, 4'hf, upm_pkg::UPM_RESP_OKAY, dummy);
		check_read("window", upm_pkg::UPM_REG_WINDOW, 32'h0000_abcd, upm_pkg::UPM_RESP_OKAY);
		// only byte 1 lands
		write_reg(upm_pkg::UPM_REG_WINDOW, 32'h1234_5678, 4'b0010, upm_pkg::UPM_RESP_OKAY, dummy);
		check_read("window byte 1", upm_pkg::UPM_REG_WINDOW, 32'h0000_56cd,
			upm_pkg::UPM_RESP_OKAY);
		write_reg(8'h1c, 32'hffff_ffff, 4'hf, upm_pkg::UPM_RESP_SLVERR, dummy);
		write_reg(upm_pkg::UPM_REG_STATUS, 32'hffff_ffff, 4'hf, upm_pkg::UPM_RESP_SLVERR, dummy);
		check_read("undefined offset", 8'h1c, 32'h0, upm_pkg::UPM_RESP_SLVERR);
		check_read("window after bad writes", upm_pkg::UPM_REG_WINDOW, 32'h0000_56cd,
			upm_pkg::UPM_RESP_OKAY);

		// apm control fields sit in bits 14:0
		apm_exp = 32'h0000_5a6b;
		write_reg(upm_pkg::UPM_REG_APM_CTRL, apm_exp, 4'hf, upm_pkg::UPM_RESP_OKAY, dummy);
		check_apm(apm_exp);
		write_reg(upm_pkg::UPM_REG_APM_CTRL, 32'hffff_ffff, 4'b0001, upm_pkg::UPM_RESP_OKAY,
			dummy);
		apm_exp = 32'h0000_5aff;
		check_apm(apm_exp);
		repeat (6) begin
			rnd = $urandom;
			strb = 4'($urandom);
			write_reg(upm_pkg::UPM_REG_APM_CTRL, rnd, strb, upm_pkg::UPM_RESP_OKAY, dummy);
			for (b = 0; b < 4; b++) begin
				if (strb[b])
					apm_exp[8*b +: 8] = rnd[8*b +: 8];
			end
			apm_exp = apm_exp & 32'h0000_7fff;
			check_apm(apm_exp);
		end

		// window mode with periods 4 and 10
		write_reg(upm_pkg::UPM_REG_WINDOW, WIN_LEN, 4'hf, upm_pkg::UPM_RESP_OKAY, dummy);
		set_osc_periods(4, 10);
		write_reg(upm_pkg::UPM_REG_CTRL, 32'h5, 4'h1, upm_pkg::UPM_RESP_OKAY, dummy);
		wait_for_done(st);
		check_eq("state after window", st.state, upm_pkg::UPM_ST_IDLE);
		check_eq("overflow after window", st.overflow, 2'b00);
		check_read("elapsed window", upm_pkg::UPM_REG_ELAPSED, WIN_LEN, upm_pkg::UPM_RESP_OKAY);
		read_reg(upm_pkg::UPM_REG_COUNT0, data, resp);
		check_range("count0", data, WIN_LEN / 4 - 1, WIN_LEN / 4 + 1);
		read_reg(upm_pkg::UPM_REG_COUNT1, data, resp);
		check_range("count1", data, WIN_LEN / 10 - 1, WIN_LEN / 10 + 1);

		// stop mode ended by a stop command and not by the short window
		write_reg(upm_pkg::UPM_REG_WINDOW, STOP_WIN, 4'hf, upm_pkg::UPM_RESP_OKAY, dummy);
		set_osc_periods(3, 7);
		write_reg(upm_pkg::UPM_REG_CTRL, 32'h1, 4'h1, upm_pkg::UPM_RESP_OKAY, hs_start);
		repeat (60 + $urandom % 100) @(negedge clk);
		write_reg(upm_pkg::UPM_REG_CTRL, 32'h2, 4'h1, upm_pkg::UPM_RESP_OKAY, hs_stop);
		wait_for_done(st);
		read_reg(upm_pkg::UPM_REG_ELAPSED, data, resp);
		check_range("elapsed in stop mode", data, STOP_WIN + 1, hs_stop - hs_start + 2);

		// long window on the aux channel with apm held low
		write_reg(upm_pkg::UPM_REG_WINDOW, LONG_WIN, 4'hf, upm_pkg::UPM_RESP_OKAY, dummy);
		set_osc_periods(0, 2);
		write_reg(upm_pkg::UPM_REG_CTRL, 32'h5, 4'h1, upm_pkg::UPM_RESP_OKAY, dummy);
		wait_for_done(st);
		check_read("long elapsed", upm_pkg::UPM_REG_ELAPSED, LONG_WIN, upm_pkg::UPM_RESP_OKAY);
		check_read("count0 held low", upm_pkg::UPM_REG_COUNT0, 32'h0, upm_pkg::UPM_RESP_OKAY);
		read_reg(upm_pkg::UPM_REG_COUNT1, data, resp);
		cnt_max = (1 << COUNT_W) - 1;
		if (LONG_WIN / 2 > cnt_max) begin
			// more edges than the counter holds
			check_eq("count1 saturated", data, cnt_max);
			check_eq("overflow saturated", st.overflow, 2'b10);
		end else begin
			check_range("count1 long", data, LONG_WIN / 2 - 1, LONG_WIN / 2 + 1);
			check_eq("overflow long", st.overflow, 2'b00);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
rtl/upm_pkg.sv
rtl/upm_osc_sync.sv
rtl/upm_axil_regs.sv
rtl/upm_window_engine.sv
rtl/upm_result_regs.sv
rtl/upm_top.sv
sim/upm_tb.sv
